//--- dv/memsched_sva.sv
// Concurrent handshake and request checks, bound into the scheduler top level
`timescale 1ns/1ps
`default_nettype none

module memsched_sva (
  input wire logic clk_i,
  input wire logic rst_ni,
  input wire logic idle_i,
  input wire logic x_req_start_o,
  input wire logic scales_zeros_valid_o,
  input wire logic scales_bias_ready_i,
  input wire logic zeros_bias_ready_i,
  input wire logic scales_skip_ready_i,
  input wire logic zeros_skip_ready_i
);

  logic all_ready;

  assign all_ready = scales_bias_ready_i & zeros_bias_ready_i &
                     scales_skip_ready_i & zeros_skip_ready_i;

  // Scales and zeros only leave when every sink can take them
  valid_needs_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    scales_zeros_valid_o |-> all_ready)
    else $error("scales/zeros valid high while a ready input is low");

  idle_blocks_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    idle_i |-> !x_req_start_o)
    else $error("X restart requested while idle");

endmodule

bind memsched_top memsched_sva sva0 (
  .clk_i                (clk_i),
  .rst_ni               (rst_ni),
  .idle_i               (idle_i),
  .x_req_start_o        (x_req_start_o),
  .scales_zeros_valid_o (scales_zeros_valid_o),
  .scales_bias_ready_i  (scales_bias_ready_i),
  .zeros_bias_ready_i   (zeros_bias_ready_i),
  .scales_skip_ready_i  (scales_skip_ready_i),
  .zeros_skip_ready_i   (zeros_skip_ready_i)
);

`default_nettype wire

//--- dv/memsched_tb.sv
// Simulation top for the scheduler that walks X tiles, sweeps W formats and random tokens and compares every cycle
`timescale 1ns/1ps
`default_nettype none

`include "memsched_defines.svh"

module memsched_tb;

  // Whole run is about 300 cycles including reset
  localparam int TIMEOUT_CYCLES = 2000;
  localparam int RAND_CYCLES    = 200;

  typedef struct packed {
    logic [`MS_ADDR_W-1:0] x_base;
    logic [`MS_LEN_W-1:0]  x_len;
    logic                  x_req;
    logic [`MS_ADDR_W-1:0] w_base;
    logic [`MS_ADDR_W-1:0] w_d0;
    logic                  w_req;
    logic [`MS_ADDR_W-1:0] q_stride;
    logic                  gidx_ready;
    logic                  row_ready;
    logic                  sz_valid;
    logic [`MS_ADDR_W-1:0] scales_bias;
    logic [`MS_ADDR_W-1:0] zeros_bias;
    logic                  skip;
    logic                  wq_valid;
    logic [`MS_ADDR_W-1:0] wq_bias;
  } expect_t;

  logic clk, rst_n;
  logic clear, start, idle, x_done, x_ready_start, w_ready_start;
  logic [`MS_ADDR_W-1:0] x_addr, x_rows_offs, w_addr, scales_addr, w_d0_stride;
  logic [31:0] x_iters, w_iters;
  logic [`MS_ITER_W-1:0] tot_x_read, row_data;
  logic [`MS_LEN_W-1:0] leftover;
  logic dequant_en, gidx_valid, row_valid;
  memsched_pkg::qint_fmt_e q_fmt;
  logic [`MS_GID_W:0] gidx_data;
  logic sb_ready, zb_ready, ss_ready, zs_ready, wq_ready;

  logic [`MS_ADDR_W-1:0] x_base_addr, w_base_addr, w_d0_stride_out;
  logic [`MS_ADDR_W-1:0] zeros_d1_stride, wq_d2_stride, scales_bias, zeros_bias, wq_bias;
  logic [`MS_LEN_W-1:0] x_tot_len;
  logic x_req_start, w_req_start, gidx_ready, row_ready, sz_valid, skip, wq_valid;

  logic [`MS_ITER_W-1:0] col_idx, wblk_idx, row_idx, done_cnt;
  logic [1:0] fmt_sel;
  expect_t exp_q;
  string test_name;
  integer seed;
  int errors = 0;
  int cycles = 0;

  tb_clock clkgen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  memsched_top dut0 (
    .clk_i (clk), .rst_ni (rst_n), .clear_i (clear), .start_i (start), .idle_i (idle),
    .x_done_i (x_done), .x_ready_start_i (x_ready_start), .w_ready_start_i (w_ready_start),
    .x_addr_i (x_addr), .x_rows_offs_i (x_rows_offs), .x_iters_i (x_iters),
    .w_iters_i (w_iters), .tot_x_read_i (tot_x_read), .leftover_i (leftover),
    .w_addr_i (w_addr), .scales_addr_i (scales_addr), .w_d0_stride_i (w_d0_stride),
    .dequant_en_i (dequant_en), .q_fmt_i (q_fmt), .gidx_valid_i (gidx_valid),
    .gidx_data_i (gidx_data), .row_valid_i (row_valid), .row_data_i (row_data),
    .scales_bias_ready_i (sb_ready), .zeros_bias_ready_i (zb_ready),
    .scales_skip_ready_i (ss_ready), .zeros_skip_ready_i (zs_ready),
    .wq_bias_ready_i (wq_ready), .x_base_addr_o (x_base_addr), .x_tot_len_o (x_tot_len),
    .x_req_start_o (x_req_start), .w_base_addr_o (w_base_addr),
    .w_d0_stride_o (w_d0_stride_out), .w_req_start_o (w_req_start),
    .zeros_d1_stride_o (zeros_d1_stride), .wq_d2_stride_o (wq_d2_stride),
    .gidx_ready_o (gidx_ready), .row_ready_o (row_ready), .scales_zeros_valid_o (sz_valid),
    .scales_bias_o (scales_bias), .zeros_bias_o (zeros_bias), .skip_o (skip),
    .wq_bias_valid_o (wq_valid), .wq_bias_o (wq_bias)
  );

  // Expected outputs from the tracked tile indices and the current inputs
  function automatic expect_t predict();
    expect_t e;
    logic [1:0] sh;
    logic [15:0] q16;
    case (q_fmt)
      memsched_pkg::QINT_2: sh = 2'd3;
      memsched_pkg::QINT_4: sh = 2'd2;
      default:              sh = 2'd1;
    endcase
    q16 = w_d0_stride[15:0] >> sh;
    e.x_base      = x_addr + 32'(row_idx) * x_rows_offs + 32'(col_idx) * 32'(`MS_JMP);
    e.x_len       = (row_idx == x_iters[31:16] - 16'd1 && leftover != '0) ?
                    leftover : `MS_ARRAY_W;
    e.x_req       = !idle && x_ready_start &&
                    (start || (done_cnt != '0 && done_cnt != tot_x_read));
    e.w_base      = dequant_en ? scales_addr : w_addr;
    e.w_d0        = dequant_en ? '0 : w_d0_stride;
    e.w_req       = start && w_ready_start;
    e.q_stride    = 32'(`MS_JMP) >> sh;
    e.gidx_ready  = sb_ready && zb_ready;
    e.row_ready   = wq_ready;
    e.sz_valid    = gidx_valid && sb_ready && zb_ready && ss_ready && zs_ready;
    e.scales_bias = 32'(gidx_data[`MS_GID_W-1:0]) * 32'(w_d0_stride[15:0]);
    e.zeros_bias  = 32'(gidx_data[`MS_GID_W-1:0]) * 32'(q16);
    e.skip        = gidx_data[`MS_GID_W];
    e.wq_valid    = row_valid && wq_ready;
    e.wq_bias     = 32'(row_data) * 32'(q16);
    return e;
  endfunction

  task automatic compare_value(input string sig, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
    assert (exp_v === act_v)
    else begin
      $display("mismatch %s %s: expected %h actual %h", test_name, sig, exp_v, act_v);
      errors++;
    end
  endtask

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic pulse_done(input int n);
    repeat (n) begin
      x_done = 1'b1;
      step();
      x_done = 1'b0;
      step();
    end
  endtask

  // Tile indices with columns innermost, then W blocks, then rows
  always @(posedge clk) begin
    if (!rst_n || clear) begin
      col_idx  <= '0;
      wblk_idx <= '0;
      row_idx  <= '0;
      done_cnt <= '0;
    end else if (x_done) begin
      done_cnt <= done_cnt + 16'd1;
      if (col_idx != x_iters[15:0] - 16'd1) begin
        col_idx <= col_idx + 16'd1;
      end else begin
        col_idx <= '0;
        if (wblk_idx != w_iters[15:0] - 16'd1) begin
          wblk_idx <= wblk_idx + 16'd1;
        end else begin
          wblk_idx <= '0;
          row_idx  <= (row_idx == x_iters[31:16] - 16'd1) ? '0 : row_idx + 16'd1;
        end
      end
    end
  end

  // Outputs are settled half a cycle after the inputs move
  always @(negedge clk) begin
    if (rst_n) begin
      exp_q = predict();
      compare_value("x_base_addr_o", exp_q.x_base, x_base_addr);
      compare_value("x_tot_len_o", 32'(exp_q.x_len), 32'(x_tot_len));
      compare_value("x_req_start_o", 32'(exp_q.x_req), 32'(x_req_start));
      compare_value("w_base_addr_o", exp_q.w_base, w_base_addr);
      compare_value("w_d0_stride_o", exp_q.w_d0, w_d0_stride_out);
      compare_value("w_req_start_o", 32'(exp_q.w_req), 32'(w_req_start));
      compare_value("zeros_d1_stride_o", exp_q.q_stride, zeros_d1_stride);
      compare_value("wq_d2_stride_o", exp_q.q_stride, wq_d2_stride);
      compare_value("gidx_ready_o", 32'(exp_q.gidx_ready), 32'(gidx_ready));
      compare_value("row_ready_o", 32'(exp_q.row_ready), 32'(row_ready));
      compare_value("scales_zeros_valid_o", 32'(exp_q.sz_valid), 32'(sz_valid));
      compare_value("scales_bias_o", exp_q.scales_bias, scales_bias);
      compare_value("zeros_bias_o", exp_q.zeros_bias, zeros_bias);
      compare_value("skip_o", 32'(exp_q.skip), 32'(skip));
      compare_value("wq_bias_valid_o", 32'(exp_q.wq_valid), 32'(wq_valid));
      compare_value("wq_bias_o", exp_q.wq_bias, wq_bias);
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("errors: %0d, timeouts: 1", errors);
      $display("Done: errors found");
      $finish;
    end
  end

  initial begin
    seed          = 46415;
    test_name     = "reset";
    clear         = 1'b0;
    start         = 1'b0;
    idle          = 1'b0;
    x_done        = 1'b0;
    x_ready_start = 1'b1;
    w_ready_start = 1'b1;
    x_addr        = 32'h0000_1000;
    x_rows_offs   = 32'h0000_0300;
    x_iters       = {16'd2, 16'd3};
    w_iters       = {16'd4, 16'd2};
    tot_x_read    = 16'd12;
    leftover      = 5'd5;
    w_addr        = 32'h0002_0000;
    scales_addr   = 32'h0003_0000;
    w_d0_stride   = 32'h0000_0100;
    dequant_en    = 1'b0;
    q_fmt         = memsched_pkg::QINT_8;
    gidx_valid    = 1'b0;
    gidx_data     = '0;
    row_valid     = 1'b0;
    row_data      = '0;
    sb_ready      = 1'b1;
    zb_ready      = 1'b1;
    ss_ready      = 1'b1;
    zs_ready      = 1'b1;
    wq_ready      = 1'b1;
    wait (rst_n);
    step();

    // Full 3 x 2 x 2 walk and then a second pass with no leftover
    test_name = "x_walk";
    pulse_done(12);
    test_name = "read_len";
    leftover = 5'd0;
    pulse_done(6);

    test_name = "x_restart";
    clear = 1'b1;
    step();
    clear = 1'b0;
    tot_x_read = 16'd4;
    start = 1'b1;
    step();
    // Start alone requests nothing from a port that is not ready
    x_ready_start = 1'b0;
    w_ready_start = 1'b0;
    step();
    start = 1'b0;
    x_ready_start = 1'b1;
    w_ready_start = 1'b1;
    step();
    pulse_done(2);
    idle = 1'b1;
    step();
    idle = 1'b0;
    x_ready_start = 1'b0;
    step();
    x_ready_start = 1'b1;
    pulse_done(2);
    repeat (3) step();

    test_name = "w_select";
    for (int f = 0; f < 3; f++) begin
      for (int d = 0; d < 2; d++) begin
        q_fmt       = memsched_pkg::qint_fmt_e'(2'(f));
        dequant_en  = 1'(d);
        w_d0_stride = $random(seed);
        step();
      end
    end

    test_name = "dequant_offs";
    repeat (RAND_CYCLES) begin
      fmt_sel     = 2'($unsigned($random(seed)) % 3);
      q_fmt       = memsched_pkg::qint_fmt_e'(fmt_sel);
      w_d0_stride = $random(seed);
      gidx_valid  = 1'($random(seed));
      gidx_data   = 9'($random(seed));
      row_valid   = 1'($random(seed));
      row_data    = 16'($random(seed));
      sb_ready    = ($unsigned($random(seed)) % 4) != 0;
      zb_ready    = ($unsigned($random(seed)) % 4) != 0;
      ss_ready    = ($unsigned($random(seed)) % 4) != 0;
      zs_ready    = ($unsigned($random(seed)) % 4) != 0;
      wq_ready    = ($unsigned($random(seed)) % 4) != 0;
      step();
    end

    // Clear in the middle of a walk restarts it from tile zero
    test_name = "clear";
    tot_x_read = 16'd12;
    leftover = 5'd7;
    pulse_done(4);
    clear = 1'b1;
    step();
    clear = 1'b0;
    pulse_done(8);
    step();

    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- dv/tb_clock.sv
// Clock and reset source for the scheduler testbench, 10 ns period and a 16-cycle reset
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // Release just after an edge so the first active cycle is clean
  initial begin
    rst_no = 1'b0;
    repeat (16) @(posedge clk_o);
    #1 rst_no = 1'b1;
  end

endmodule

`default_nettype wire

//--- logic/dequant_offset.sv
// Group and row tokens to byte offsets for scales, zeros and packed weights, zero latency
`timescale 1ns/1ps
`default_nettype none

`include "memsched_defines.svh"

module dequant_offset (
  input  wire logic                  gidx_valid_i,
  input  wire logic [`MS_GID_W:0]    gidx_data_i,
  input  wire logic                  row_valid_i,
  input  wire logic [`MS_ITER_W-1:0] row_data_i,
  input  wire logic                  scales_bias_ready_i,
  input  wire logic                  zeros_bias_ready_i,
  input  wire logic                  scales_skip_ready_i,
  input  wire logic                  zeros_skip_ready_i,
  input  wire logic                  wq_bias_ready_i,
  memsched_cfg_if.dst                cfg,
  output logic                       gidx_ready_o,
  output logic                       row_ready_o,
  output logic                       scales_zeros_valid_o,
  output logic [`MS_ADDR_W-1:0]      scales_bias_o,
  output logic [`MS_ADDR_W-1:0]      zeros_bias_o,
  output logic                       skip_o,
  output logic                       wq_bias_valid_o,
  output logic [`MS_ADDR_W-1:0]      wq_bias_o
);

  logic [15:0]           row_stride;
  logic [15:0]           q_stride;
  logic [`MS_ADDR_W-1:0] gid_ext, row_ext, stride_ext, q_stride_ext;

  // Only the low half of the W row stride matters for offsets
  assign row_stride = cfg.w_d0_stride[15:0];
  assign q_stride   = row_stride >> memsched_pkg::q_shift(cfg.q_fmt);

  assign gid_ext      = {{(`MS_ADDR_W - `MS_GID_W){1'b0}}, gidx_data_i[`MS_GID_W-1:0]};
  assign row_ext      = {{(`MS_ADDR_W - `MS_ITER_W){1'b0}}, row_data_i};
  assign stride_ext   = {{(`MS_ADDR_W - 16){1'b0}}, row_stride};
  assign q_stride_ext = {{(`MS_ADDR_W - 16){1'b0}}, q_stride};

  assign scales_bias_o = gid_ext * stride_ext;
  assign zeros_bias_o  = gid_ext * q_stride_ext;
  assign wq_bias_o     = row_ext * q_stride_ext;
  assign skip_o        = gidx_data_i[`MS_GID_W];

  // Scales and zeros leave together, so all four sinks must accept
  assign gidx_ready_o         = scales_bias_ready_i & zeros_bias_ready_i;
  assign scales_zeros_valid_o = gidx_valid_i & scales_bias_ready_i & zeros_bias_ready_i &
                                scales_skip_ready_i & zeros_skip_ready_i;

  assign row_ready_o     = wq_bias_ready_i;
  assign wq_bias_valid_o = row_valid_i & wq_bias_ready_i;

endmodule

`default_nettype wire

//--- logic/memsched_cfg_if.sv
// Job configuration bundle, driven by the scheduler top level and read by its submodules
`timescale 1ns/1ps
`default_nettype none

`include "memsched_defines.svh"

interface memsched_cfg_if;

  logic [`MS_ITER_W-1:0] x_cols_iters;
  logic [`MS_ITER_W-1:0] x_rows_iters;
  logic [`MS_ITER_W-1:0] w_cols_iters;
  logic [`MS_ITER_W-1:0] w_rows_iters;
  logic [`MS_ADDR_W-1:0] w_d0_stride;
  logic                  dequant_en;
  memsched_pkg::qint_fmt_e q_fmt;

  modport src (
    output x_cols_iters, x_rows_iters, w_cols_iters, w_rows_iters,
    output w_d0_stride, dequant_en, q_fmt
  );

  modport dst (
    input x_cols_iters, x_rows_iters, w_cols_iters, w_rows_iters,
    input w_d0_stride, dequant_en, q_fmt
  );

endinterface

`default_nettype wire

//--- logic/memsched_defines.svh
// Widths and fixed geometry of the memory scheduler, included by every RTL file that sizes a port
`ifndef MEMSCHED_DEFINES_SVH
`define MEMSCHED_DEFINES_SVH

// Addresses, strides and byte offsets
`define MS_ADDR_W 32

// Each iteration count of the tile walk
`define MS_ITER_W 16

// Rows of the systolic array, also the default X read length
`define MS_ARRAY_W 12
`define MS_LEN_W 5

// Byte step between neighbouring column blocks
`define MS_JMP 64

// Group index width, a token adds the skip flag on top
`define MS_GID_W 8

`endif

//--- logic/memsched_pkg.sv
// Quantization format type and its shift helper, referenced by scoped name from the RTL
`default_nettype none

package memsched_pkg;

  typedef enum logic [1:0] {
    QINT_8 = 2'd0,
    QINT_4 = 2'd1,
    QINT_2 = 2'd2
  } qint_fmt_e;

  // Narrower formats pack more weights per byte, so strides shrink
  function automatic logic [1:0] q_shift(qint_fmt_e fmt);
    logic [1:0] sh;
    case (fmt)
      QINT_2:  sh = 2'd3;
      QINT_4:  sh = 2'd2;
      default: sh = 2'd1;
    endcase
    return sh;
  endfunction

endpackage

`default_nettype wire

//--- logic/memsched_top.sv
// Memory scheduler top level with plain ports that fans the job configuration out to the submodules
`timescale 1ns/1ps
`default_nettype none

`include "memsched_defines.svh"

module memsched_top (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  input  wire logic                  clear_i,
  input  wire logic                  start_i,
  input  wire logic                  idle_i,
  input  wire logic                  x_done_i,
  input  wire logic                  x_ready_start_i,
  input  wire logic                  w_ready_start_i,
  input  wire logic [`MS_ADDR_W-1:0] x_addr_i,
  input  wire logic [`MS_ADDR_W-1:0] x_rows_offs_i,
  input  wire logic [31:0]           x_iters_i,
  input  wire logic [31:0]           w_iters_i,
  input  wire logic [`MS_ITER_W-1:0] tot_x_read_i,
  input  wire logic [`MS_LEN_W-1:0]  leftover_i,
  input  wire logic [`MS_ADDR_W-1:0] w_addr_i,
  input  wire logic [`MS_ADDR_W-1:0] scales_addr_i,
  input  wire logic [`MS_ADDR_W-1:0] w_d0_stride_i,
  input  wire logic                  dequant_en_i,
  input  wire memsched_pkg::qint_fmt_e q_fmt_i,
  input  wire logic                  gidx_valid_i,
  input  wire logic [`MS_GID_W:0]    gidx_data_i,
  input  wire logic                  row_valid_i,
  input  wire logic [`MS_ITER_W-1:0] row_data_i,
  input  wire logic                  scales_bias_ready_i,
  input  wire logic                  zeros_bias_ready_i,
  input  wire logic                  scales_skip_ready_i,
  input  wire logic                  zeros_skip_ready_i,
  input  wire logic                  wq_bias_ready_i,
  output logic [`MS_ADDR_W-1:0]      x_base_addr_o,
  output logic [`MS_LEN_W-1:0]       x_tot_len_o,
  output logic                       x_req_start_o,
  output logic [`MS_ADDR_W-1:0]      w_base_addr_o,
  output logic [`MS_ADDR_W-1:0]      w_d0_stride_o,
  output logic                       w_req_start_o,
  output logic [`MS_ADDR_W-1:0]      zeros_d1_stride_o,
  output logic [`MS_ADDR_W-1:0]      wq_d2_stride_o,
  output logic                       gidx_ready_o,
  output logic                       row_ready_o,
  output logic                       scales_zeros_valid_o,
  output logic [`MS_ADDR_W-1:0]      scales_bias_o,
  output logic [`MS_ADDR_W-1:0]      zeros_bias_o,
  output logic                       skip_o,
  output logic                       wq_bias_valid_o,
  output logic [`MS_ADDR_W-1:0]      wq_bias_o
);

  memsched_cfg_if cfg ();

  // Iteration words carry rows in the upper half and columns in the lower half
  assign cfg.x_cols_iters = x_iters_i[15:0];
  assign cfg.x_rows_iters = x_iters_i[31:16];
  assign cfg.w_cols_iters = w_iters_i[15:0];
  assign cfg.w_rows_iters = w_iters_i[31:16];
  assign cfg.w_d0_stride  = w_d0_stride_i;
  assign cfg.dequant_en   = dequant_en_i;
  assign cfg.q_fmt        = q_fmt_i;

  x_tile_walker u_x_walker (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .clear_i         (clear_i),
    .start_i         (start_i),
    .idle_i          (idle_i),
    .x_done_i        (x_done_i),
    .x_ready_start_i (x_ready_start_i),
    .x_addr_i        (x_addr_i),
    .x_rows_offs_i   (x_rows_offs_i),
    .tot_x_read_i    (tot_x_read_i),
    .leftover_i      (leftover_i),
    .cfg             (cfg.dst),
    .x_base_addr_o   (x_base_addr_o),
    .x_tot_len_o     (x_tot_len_o),
    .x_req_start_o   (x_req_start_o)
  );

  w_stream_cfg u_w_cfg (
    .start_i           (start_i),
    .w_ready_start_i   (w_ready_start_i),
    .w_addr_i          (w_addr_i),
    .scales_addr_i     (scales_addr_i),
    .cfg               (cfg.dst),
    .w_base_addr_o     (w_base_addr_o),
    .w_d0_stride_o     (w_d0_stride_o),
    .w_req_start_o     (w_req_start_o),
    .zeros_d1_stride_o (zeros_d1_stride_o),
    .wq_d2_stride_o    (wq_d2_stride_o)
  );

  dequant_offset u_dq_offs (
    .gidx_valid_i         (gidx_valid_i),
    .gidx_data_i          (gidx_data_i),
    .row_valid_i          (row_valid_i),
    .row_data_i           (row_data_i),
    .scales_bias_ready_i  (scales_bias_ready_i),
    .zeros_bias_ready_i   (zeros_bias_ready_i),
    .scales_skip_ready_i  (scales_skip_ready_i),
    .zeros_skip_ready_i   (zeros_skip_ready_i),
    .wq_bias_ready_i      (wq_bias_ready_i),
    .cfg                  (cfg.dst),
    .gidx_ready_o         (gidx_ready_o),
    .row_ready_o          (row_ready_o),
    .scales_zeros_valid_o (scales_zeros_valid_o),
    .scales_bias_o        (scales_bias_o),
    .zeros_bias_o         (zeros_bias_o),
    .skip_o               (skip_o),
    .wq_bias_valid_o      (wq_bias_valid_o),
    .wq_bias_o            (wq_bias_o)
  );

endmodule

`default_nettype wire

//--- logic/w_stream_cfg.sv
// W stream descriptor selection and dequantization strides, purely combinational
`timescale 1ns/1ps
`default_nettype none

`include "memsched_defines.svh"

module w_stream_cfg (
  input  wire logic                  start_i,
  input  wire logic                  w_ready_start_i,
  input  wire logic [`MS_ADDR_W-1:0] w_addr_i,
  input  wire logic [`MS_ADDR_W-1:0] scales_addr_i,
  memsched_cfg_if.dst                cfg,
  output logic [`MS_ADDR_W-1:0]      w_base_addr_o,
  output logic [`MS_ADDR_W-1:0]      w_d0_stride_o,
  output logic                       w_req_start_o,
  output logic [`MS_ADDR_W-1:0]      zeros_d1_stride_o,
  output logic [`MS_ADDR_W-1:0]      wq_d2_stride_o
);

  localparam logic [`MS_ADDR_W-1:0] jmp = `MS_JMP;

  logic [1:0]            shift;
  logic [`MS_ADDR_W-1:0] packed_stride;

  assign shift         = memsched_pkg::q_shift(cfg.q_fmt);
  assign packed_stride = jmp >> shift;

  // With dequantization on, the W port fetches scales, one per column block
  always_comb begin
    if (cfg.dequant_en) begin
      w_base_addr_o = scales_addr_i;
      w_d0_stride_o = '0;
    end else begin
      w_base_addr_o = w_addr_i;
      w_d0_stride_o = cfg.w_d0_stride;
    end
  end

  assign zeros_d1_stride_o = packed_stride;
  assign wq_d2_stride_o    = packed_stride;

  // W is loaded once per job
  assign w_req_start_o = start_i & w_ready_start_i;

endmodule

`default_nettype wire

//--- logic/x_tile_walker.sv
// X operand tile walk: nested counters, base address, read length and the X restart request
`timescale 1ns/1ps
`default_nettype none

`include "memsched_defines.svh"

module x_tile_walker (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  input  wire logic                  clear_i,
  input  wire logic                  start_i,
  input  wire logic                  idle_i,
  input  wire logic                  x_done_i,
  input  wire logic                  x_ready_start_i,
  input  wire logic [`MS_ADDR_W-1:0] x_addr_i,
  input  wire logic [`MS_ADDR_W-1:0] x_rows_offs_i,
  input  wire logic [`MS_ITER_W-1:0] tot_x_read_i,
  input  wire logic [`MS_LEN_W-1:0]  leftover_i,
  memsched_cfg_if.dst                cfg,
  output logic [`MS_ADDR_W-1:0]      x_base_addr_o,
  output logic [`MS_LEN_W-1:0]       x_tot_len_o,
  output logic                       x_req_start_o
);

  localparam logic [`MS_ADDR_W-1:0] jmp       = `MS_JMP;
  localparam logic [`MS_LEN_W-1:0]  array_len = `MS_ARRAY_W;

  logic [`MS_ITER_W-1:0] cols_q, w_q, rows_q, tot_q;
  logic [`MS_ITER_W-1:0] cols_last, w_last, rows_last;
  logic [`MS_ADDR_W-1:0] col_offs_q, row_offs_q;
  logic                  col_wrap, w_wrap, row_wrap;
  logic                  w_step, row_step;

  assign cols_last = cfg.x_cols_iters - 1'b1;
  assign w_last    = cfg.w_cols_iters - 1'b1;
  assign rows_last = cfg.x_rows_iters - 1'b1;

  assign col_wrap = (cols_q == cols_last);
  assign w_wrap   = (w_q == w_last);
  assign row_wrap = (rows_q == rows_last);

  // Columns innermost, then W blocks, then X rows
  assign w_step   = x_done_i & col_wrap;
  assign row_step = w_step & w_wrap;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cols_q     <= '0;
      w_q        <= '0;
      rows_q     <= '0;
      tot_q      <= '0;
      col_offs_q <= '0;
      row_offs_q <= '0;
    end else if (clear_i) begin
      cols_q     <= '0;
      w_q        <= '0;
      rows_q     <= '0;
      tot_q      <= '0;
      col_offs_q <= '0;
      row_offs_q <= '0;
    end else begin
      if (x_done_i) begin
        tot_q      <= tot_q + 1'b1;
        cols_q     <= col_wrap ? '0 : cols_q + 1'b1;
        col_offs_q <= col_wrap ? '0 : col_offs_q + jmp;
      end
      if (w_step) begin
        w_q <= w_wrap ? '0 : w_q + 1'b1;
      end
      if (row_step) begin
        rows_q     <= row_wrap ? '0 : rows_q + 1'b1;
        row_offs_q <= row_wrap ? '0 : row_offs_q + x_rows_offs_i;
      end
    end
  end

  assign x_base_addr_o = x_addr_i + row_offs_q + col_offs_q;

  // Last row block is shorter when the row count leaves a remainder
  assign x_tot_len_o = (row_wrap && leftover_i != '0) ? leftover_i : array_len;

  // Keep restarting the X stream until every planned read has been issued
  assign x_req_start_o = !idle_i && x_ready_start_i &&
                         (start_i || (tot_q != '0 && tot_q != tot_x_read_i));

endmodule

`default_nettype wire

//--- project.f
+incdir+logic
logic/memsched_pkg.sv
logic/memsched_cfg_if.sv
logic/x_tile_walker.sv
logic/w_stream_cfg.sv
logic/dequant_offset.sv
logic/memsched_top.sv
dv/tb_clock.sv
dv/memsched_sva.sv
dv/memsched_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the scheduler testbench with Verilator, then check the log

cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module memsched_tb -f project.f -Mdir obj_dir -o memsched_sim &&
./obj_dir/memsched_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^Done: no errors$" sim.log 2>/dev/null && echo "PASS" || {
  echo "FAIL"
  exit 1
}
